//--- verilog/pcie_dbg_macros.svh
// PCIe debug status block parameters
// Ring geometry, counter width and APB register offsets
`ifndef PCIE_DBG_MACROS_SVH
`define PCIE_DBG_MACROS_SVH

// Trace ring geometry
`define PCIE_DBG_DEPTH      16
`define PCIE_DBG_IDX_W      4

// Memory request counter, wraps at 2^31
`define PCIE_DBG_CNT_W      31

// APB byte offsets
`define PCIE_DBG_REG_STATE  12'h000    // DMA engine state
`define PCIE_DBG_REG_ID     12'h004    // Bus, device, function
`define PCIE_DBG_REG_CNT    12'h008    // Request counter
`define PCIE_DBG_REG_RING   12'h080    // Ring window, 0x080..0x0FF

`endif

//--- verilog/pcie_dbg_pkg.sv
// PCIe debug status types
// APB request/response, debug memory strobe payload and stored trace record
package pcie_dbg_pkg;

    // APB requester to completer, 47 bits
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;     // 4 KB window
        logic [31:0] pwdata;
    } apb_req_t;

    // APB completer to requester, 34 bits
    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // Endpoint memory-request port, one strobe
    typedef struct packed {
        logic        wren;      // Write access
        logic [7:0]  wstrb;     // Byte lanes
        logic [12:0] addr;      // Word address in BAR
        logic [31:0] data;
    } dbg_mem_req_t;

    // One ring entry, 64 bits
    typedef struct packed {
        logic        wren;      // Bit 63
        logic [9:0]  rsvd;      // Bits 62..53, always zero
        logic [7:0]  wstrb;     // Bits 52..45
        logic [12:0] addr;      // Bits 44..32
        logic [31:0] data;      // Bits 31..0
    } trace_rec_t;

endpackage

//--- verilog/dbg_mem_capture.sv
// Debug memory request capture
// Registers every endpoint memory strobe into a trace record, issues
// a ring write one cycle later and counts the requests
`timescale 1ns/1ns
`include "pcie_dbg_macros.svh"

module dbg_mem_capture (
    input  logic                           i_clk,
    input  logic                           i_nrst,
    input  logic                           i_dbg_valid,    // Single-cycle strobe
    input  pcie_dbg_pkg::dbg_mem_req_t     i_dbg_req,
    output logic                           o_wr_en,        // Ring write pulse
    output logic [`PCIE_DBG_IDX_W-1:0]     o_wr_idx,
    output pcie_dbg_pkg::trace_rec_t       o_wr_rec,
    output logic [`PCIE_DBG_CNT_W-1:0]     o_req_cnt
);
    import pcie_dbg_pkg::*;

    trace_rec_t                rec_d;      // Strobe packed as a record
    trace_rec_t                rec_q;      // Record waiting for the ring
    logic                      wr_en_q;
    logic [`PCIE_DBG_CNT_W-1:0] cnt_q;

    // Pack payload into the stored layout
    always_comb begin
        rec_d.wren  = i_dbg_req.wren;
        rec_d.rsvd  = '0;
        rec_d.wstrb = i_dbg_req.wstrb;
        rec_d.addr  = i_dbg_req.addr;
        rec_d.data  = i_dbg_req.data;
    end

    // One write pulse per strobe
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= i_dbg_valid;
        end
    end

    // Record register, loads on every strobe
    always_ff @(posedge i_clk) begin
        if (i_dbg_valid) begin
            rec_q <= rec_d;
        end
    end

    // Counter steps together with the ring write
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt_q <= '0;
        end else if (wr_en_q) begin
            cnt_q <= cnt_q + `PCIE_DBG_CNT_W'(1);     // Wraps at 2^31
        end
    end

    assign o_wr_en   = wr_en_q;
    assign o_wr_idx  = cnt_q[`PCIE_DBG_IDX_W-1:0];   // Slot = count before increment
    assign o_wr_rec  = rec_q;
    assign o_req_cnt = cnt_q;

endmodule

//--- verilog/trace_ring.sv
// Trace ring buffer
// Keeps the last 16 trace records, oldest overwritten first
// One synchronous write port, one asynchronous indexed read port
`timescale 1ns/1ns
`include "pcie_dbg_macros.svh"

module trace_ring (
    input  logic                        i_clk,
    input  logic                        i_wr_en,
    input  logic [`PCIE_DBG_IDX_W-1:0]  i_wr_idx,
    input  pcie_dbg_pkg::trace_rec_t    i_wr_rec,
    input  logic [`PCIE_DBG_IDX_W-1:0]  i_rd_idx,
    output pcie_dbg_pkg::trace_rec_t    o_rd_rec
);
    import pcie_dbg_pkg::*;

    // Storage, maps to distributed RAM
    trace_rec_t mem [0:`PCIE_DBG_DEPTH-1];

    // Write at the clock edge
    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_wr_idx] <= i_wr_rec;
        end
    end

    // Zero-latency read
    assign o_rd_rec = mem[i_rd_idx];

endmodule

//--- verilog/apb_pcie_regs.sv
// APB register block for PCIe debug status
// Read-only map of DMA state, completer ID, request counter and trace ring
// Fixed three-cycle transfers with a registered response, writes error out
`timescale 1ns/1ns
`include "pcie_dbg_macros.svh"

module apb_pcie_regs (
    input  logic                        i_clk,
    input  logic                        i_nrst,
    input  pcie_dbg_pkg::apb_req_t      i_apb,
    output pcie_dbg_pkg::apb_rsp_t      o_apb,
    input  logic [3:0]                  i_dma_state,      // DMA engine brief state
    input  logic [15:0]                 i_completer_id,   // Bus, device, function
    input  logic [`PCIE_DBG_CNT_W-1:0]  i_req_cnt,
    output logic [`PCIE_DBG_IDX_W-1:0]  o_rd_idx,
    input  pcie_dbg_pkg::trace_rec_t    i_rd_rec
);
    import pcie_dbg_pkg::*;

    // Word-aligned decode bases
    localparam logic [11:0] off_state = `PCIE_DBG_REG_STATE;
    localparam logic [11:0] off_id    = `PCIE_DBG_REG_ID;
    localparam logic [11:0] off_cnt   = `PCIE_DBG_REG_CNT;
    localparam logic [11:0] off_ring  = `PCIE_DBG_REG_RING;

    logic        acc_q;       // Setup seen, first access cycle pending
    logic        done;        // Second access cycle starts next
    logic [31:0] rdata;       // Read mux output
    apb_rsp_t    rsp_d;
    apb_rsp_t    rsp_q;

    // Wait state tracking
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            acc_q <= 1'b0;
        end else begin
            acc_q <= i_apb.psel & ~i_apb.penable;   // Set only by a setup cycle
        end
    end

    // End of first access cycle
    assign done = i_apb.psel & i_apb.penable & acc_q;

    // Ring slot straight from the address
    assign o_rd_idx = i_apb.paddr[`PCIE_DBG_IDX_W+2:3];

    // Read multiplexer on paddr[11:2]
    always_comb begin
        rdata = '0;   // Unmapped reads return zero
        if (i_apb.paddr[11:2] == off_state[11:2]) begin
            rdata[3:0] = i_dma_state;
        end else if (i_apb.paddr[11:2] == off_id[11:2]) begin
            rdata[15:0] = i_completer_id;
        end else if (i_apb.paddr[11:2] == off_cnt[11:2]) begin
            rdata = {{(32-`PCIE_DBG_CNT_W){1'b0}}, i_req_cnt};   // Zero-extended
        end else if (i_apb.paddr[11:7] == off_ring[11:7]) begin
            // paddr[2] picks the record half
            if (i_apb.paddr[2]) begin
                rdata = i_rd_rec[63:32];
            end else begin
                rdata = i_rd_rec[31:0];
            end
        end
    end

    // Next response
    always_comb begin
        rsp_d.pready  = done;
        rsp_d.pslverr = done & i_apb.pwrite;          // Every register is read-only
        rsp_d.prdata  = (done & ~i_apb.pwrite) ? rdata : '0;
    end

    // Registered response, held for the one pready cycle
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rsp_q <= '0;
        end else begin
            rsp_q <= rsp_d;
        end
    end

    assign o_apb = rsp_q;

endmodule

//--- verilog/pcie_dbg_top.sv
// PCIe debug status block, top level
// Capture feeds the trace ring, the APB register block reads both
`timescale 1ns/1ns
`include "pcie_dbg_macros.svh"

module pcie_dbg_top (
    input  logic                         i_clk,
    input  logic                         i_nrst,
    input  pcie_dbg_pkg::apb_req_t       i_apb,
    output pcie_dbg_pkg::apb_rsp_t       o_apb,
    input  logic                         i_dbg_valid,      // Memory request strobe
    input  pcie_dbg_pkg::dbg_mem_req_t   i_dbg_req,
    input  logic [3:0]                   i_dma_state,
    input  logic [15:0]                  i_completer_id
);
    import pcie_dbg_pkg::*;

    logic                       wr_en;       // Capture to ring
    logic [`PCIE_DBG_IDX_W-1:0] wr_idx;
    trace_rec_t                 wr_rec;
    logic [`PCIE_DBG_CNT_W-1:0] req_cnt;     // Capture to registers
    logic [`PCIE_DBG_IDX_W-1:0] rd_idx;      // Registers to ring
    trace_rec_t                 rd_rec;

    dbg_mem_capture u_capture (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_dbg_valid (i_dbg_valid),
        .i_dbg_req   (i_dbg_req),
        .o_wr_en     (wr_en),
        .o_wr_idx    (wr_idx),
        .o_wr_rec    (wr_rec),
        .o_req_cnt   (req_cnt)
    );

    trace_ring u_ring (
        .i_clk    (i_clk),
        .i_wr_en  (wr_en),
        .i_wr_idx (wr_idx),
        .i_wr_rec (wr_rec),
        .i_rd_idx (rd_idx),
        .o_rd_rec (rd_rec)
    );

    apb_pcie_regs u_regs (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_apb          (i_apb),
        .o_apb          (o_apb),
        .i_dma_state    (i_dma_state),
        .i_completer_id (i_completer_id),
        .i_req_cnt      (req_cnt),
        .o_rd_idx       (rd_idx),
        .i_rd_rec       (rd_rec)
    );

endmodule

//--- verif/pcie_dbg_assertions.sv
// APB protocol checks for the PCIe debug register block
// Bound into apb_pcie_regs, watches the request and the registered response
`timescale 1ns/1ns

module pcie_dbg_assertions (
    input logic                    i_clk,
    input logic                    i_nrst,
    input pcie_dbg_pkg::apb_req_t  i_apb,
    input pcie_dbg_pkg::apb_rsp_t  i_rsp
);

    logic setup_cyc;
    logic access_cyc;

    assign setup_cyc  = i_apb.psel & ~i_apb.penable;
    assign access_cyc = i_apb.psel & i_apb.penable;

    // Single-cycle pready
    pready_one_cycle: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_rsp.pready |=> !i_rsp.pready
    ) else $error("pready held high for more than one cycle");

    // Only in the second access cycle
    pready_second_access: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_rsp.pready |-> (access_cyc && $past(access_cyc) && $past(setup_cyc, 2))
    ) else $error("pready outside the second access cycle");

    // First access cycle always followed by pready
    pready_on_time: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (access_cyc && $past(setup_cyc)) |=> i_rsp.pready
    ) else $error("pready missing in the second access cycle");

    pslverr_with_pready: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        i_rsp.pslverr |-> i_rsp.pready
    ) else $error("pslverr high without pready");

    // Response quiet while in reset
    quiet_in_reset: assert property (
        @(posedge i_clk)
        !i_nrst |-> (i_rsp == '0)
    ) else $error("APB response active during reset");

endmodule

//--- verif/tb_pcie_dbg.sv
// Testbench for the PCIe debug status block
// Replays the command list from the stimulus file over the debug strobe
// port and APB, checks every response against the expected values
`timescale 1ns/1ns

module tb_pcie_dbg;
    import pcie_dbg_pkg::*;

    localparam int RST_CYCLES = 8;
    localparam int CMD_CYCLES = 6;      // Budget per command
    localparam int MARGIN     = 50;

    logic          clk;
    logic          nrst;
    apb_req_t      apb_req;
    apb_rsp_t      apb_rsp;
    logic          dbg_valid;
    dbg_mem_req_t  dbg_req;
    logic [3:0]    dma_state;
    logic [15:0]   completer_id;

    int fd;
    int n_cmds;
    int limit  = 0;         // Set once the command count is known
    int cycles = 0;
    int pass_cnt;
    int fail_cnt;
    bit setup_err;          // Stimulus file unusable

    pcie_dbg_top u_pcie_dbg_top (
        .i_clk          (clk),
        .i_nrst         (nrst),
        .i_apb          (apb_req),
        .o_apb          (apb_rsp),
        .i_dbg_valid    (dbg_valid),
        .i_dbg_req      (dbg_req),
        .i_dma_state    (dma_state),
        .i_completer_id (completer_id)
    );

    // Protocol checks inside the register block
    bind apb_pcie_regs pcie_dbg_assertions u_apb_checks (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_apb  (i_apb),
        .i_rsp  (o_apb)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;       // 10 ns period

    // Watchdog, catches a missing pready
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout: no result after %0d cycles, an APB transfer never completed",
                     cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Next non-comment token, comment lines start with #
    task automatic next_command(output string cmd, output int got);
        int    n;
        string rest;
        bit    done;
        got  = 0;
        done = 1'b0;
        cmd  = "";
        while (!done) begin
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                done = 1'b1;                    // End of file
            end else if (cmd[0] == "#") begin
                n = $fgets(rest, fd);           // Drop rest of comment
            end else begin
                got  = 1;
                done = 1'b1;
            end
        end
    endtask

    // Field count of one command line
    task automatic expect_fields(input int n, input int want, input string cmd);
        if (n != want) begin
            $display("Malformed %s line in the stimulus file, %0d of %0d fields read",
                     cmd, n, want);
            setup_err = 1'b1;
        end
    endtask

    function automatic dbg_mem_req_t make_req(input logic [31:0] wren,
                                              input logic [31:0] wstrb,
                                              input logic [31:0] addr,
                                              input logic [31:0] data);
        dbg_mem_req_t req;
        req.wren  = wren[0];
        req.wstrb = wstrb[7:0];
        req.addr  = addr[12:0];
        req.data  = data;
        return req;
    endfunction

    // Back-to-back strobes, addr and data step by one
    task automatic send_strobes(input int count, input dbg_mem_req_t base);
        dbg_mem_req_t req;
        req = base;
        for (int k = 0; k < count; k++) begin
            dbg_req   = req;
            dbg_valid = 1'b1;
            @(posedge clk);
            @(negedge clk);
            req.addr = req.addr + 13'd1;
            req.data = req.data + 32'd1;
        end
        dbg_valid = 1'b0;
    endtask

    // One APB transfer, returns at a falling edge
    task automatic apb_transfer(input logic wr, input logic [11:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        apb_req.psel    = 1'b1;         // Setup
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(posedge clk);
        @(negedge clk);
        apb_req.penable = 1'b1;         // Access, held until pready
        @(posedge clk);
        @(negedge clk);
        while (!apb_rsp.pready) begin
            @(posedge clk);
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;         // Mid-cycle, stable
        err   = apb_rsp.pslverr;
        @(posedge clk);                 // Completion edge
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic check_response(input string name, input bit chk_data,
                                  input logic [31:0] exp_data, input logic [31:0] act_data,
                                  input logic exp_err, input logic act_err);
        bit ok;
        ok = 1'b1;
        if (chk_data) begin
            assert (act_data == exp_data) else begin
                $display("Fail %s: expected prdata %08h, actual %08h",
                         name, exp_data, act_data);
                ok = 1'b0;
            end
        end
        assert (act_err == exp_err) else begin
            $display("Fail %s: expected pslverr %0d, actual %0d", name, exp_err, act_err);
            ok = 1'b0;
        end
        if (ok) begin
            pass_cnt++;
            $display("Test %s passed", name);
        end else begin
            fail_cnt++;
            $display("Test %s failed", name);
        end
    endtask

    initial begin : main
        string         cmd;
        string         name;
        logic [31:0]   f_a;
        logic [31:0]   f_b;
        logic [31:0]   f_c;
        logic [31:0]   f_d;
        logic [31:0]   f_e;
        logic [31:0]   rdata;
        logic          err;
        int            got;
        int            n;
        int            idx;

        nrst         = 1'b0;
        apb_req      = '0;
        dbg_valid    = 1'b0;
        dbg_req      = '0;
        dma_state    = '0;
        completer_id = '0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        setup_err    = 1'b0;
        n_cmds       = 0;

        fd = $fopen("verif/pcie_dbg_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file verif/pcie_dbg_stim.txt");
            setup_err = 1'b1;
        end else begin
            next_command(cmd, got);
            if (got == 1 && cmd == "count") begin
                n = $fscanf(fd, "%d", n_cmds);
                expect_fields(n, 1, cmd);
            end else begin
                $display("Stimulus file does not start with a command count");
                setup_err = 1'b1;
            end
        end
        limit = RST_CYCLES + CMD_CYCLES * n_cmds + MARGIN;

        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        nrst = 1'b1;

        idx = 0;
        while (!setup_err && idx < n_cmds) begin
            next_command(cmd, got);
            if (got == 0) begin
                $display("Stimulus file ended after %0d of %0d commands", idx, n_cmds);
                setup_err = 1'b1;
            end else if (cmd == "levels") begin
                n = $fscanf(fd, "%s %h %h", name, f_a, f_b);
                expect_fields(n, 3, cmd);
                dma_state    = f_a[3:0];
                completer_id = f_b[15:0];
            end else if (cmd == "strobe") begin
                n = $fscanf(fd, "%s %h %h %h %h", name, f_a, f_b, f_c, f_d);
                expect_fields(n, 5, cmd);
                send_strobes(1, make_req(f_a, f_b, f_c, f_d));
            end else if (cmd == "burst") begin
                n = $fscanf(fd, "%s %d %h %h %h %h", name, f_a, f_b, f_c, f_d, f_e);
                expect_fields(n, 6, cmd);
                send_strobes(f_a, make_req(f_b, f_c, f_d, f_e));
            end else if (cmd == "read") begin
                n = $fscanf(fd, "%s %h %h %h", name, f_a, f_b, f_c);
                expect_fields(n, 4, cmd);
                apb_transfer(1'b0, f_a[11:0], 32'd0, rdata, err);
                check_response(name, 1'b1, f_b, rdata, f_c[0], err);
            end else if (cmd == "write") begin
                n = $fscanf(fd, "%s %h %h %h", name, f_a, f_b, f_c);
                expect_fields(n, 4, cmd);
                apb_transfer(1'b1, f_a[11:0], f_b, rdata, err);
                check_response(name, 1'b0, 32'd0, rdata, f_c[0], err);   // Status only
            end else begin
                $display("Unknown command %s in the stimulus file", cmd);
                setup_err = 1'b1;
            end
            idx++;
        end

        if (fd != 0) begin
            $fclose(fd);
        end
        $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !setup_err && pass_cnt > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verif/pcie_dbg_stim.txt
# Columns: cmd name, then hex fields; levels: state id; strobe: wren wstrb addr data
# burst: count(dec) wren wstrb addr data (+1 per strobe); read/write: paddr data pslverr
count 29
# Levels and counter straight after reset
levels init_levels      a 1234
read   cnt_after_reset  008 00000000 0
read   state_reset      000 0000000a 0
read   id_reset         004 00001234 0
# One strobe, lands in entry 0
strobe single_wr        1 f0 1abc deadbeef
read   single_lo        080 deadbeef 0
read   single_hi        084 801e1abc 0
read   single_cnt       008 00000001 0
# 20 strobes, strobes 17..21 wrap into entries 0..4
burst  burst20          20 0 0f 0100 10000000
read   burst_cnt        008 00000015 0
read   e0_lo            080 1000000f 0
read   e0_hi            084 0001e10f 0
read   e1_lo            088 10000010 0
read   e4_lo            0a0 10000013 0
read   e4_hi            0a4 0001e113 0
read   e5_lo            0a8 10000004 0
read   e5_hi            0ac 0001e104 0
read   e15_lo           0f8 1000000e 0
read   e15_hi           0fc 0001e10e 0
# Unmapped offsets read zero
read   unmapped_010     010 00000000 0
read   unmapped_100     100 00000000 0
read   unmapped_07c     07c 00000000 0
# Writes error out and change nothing
write  wr_cnt           008 ffffffff 1
read   cnt_after_wr     008 00000015 0
write  wr_ring          080 12345678 1
read   ring_after_wr    080 1000000f 0
# Levels sampled at read time
levels new_levels       3 beef
read   state_new        000 00000003 0
read   id_new           004 0000beef 0

//--- filelist.f
+incdir+verilog
verilog/pcie_dbg_pkg.sv
verilog/dbg_mem_capture.sv
verilog/trace_ring.sv
verilog/apb_pcie_regs.sv
verilog/pcie_dbg_top.sv
verif/pcie_dbg_assertions.sv
verif/tb_pcie_dbg.sv

//--- Makefile
# Verilator flow for the PCIe debug status block

VERILATOR ?= verilator
TOP       ?= tb_pcie_dbg
RTL_TOP   ?= pcie_dbg_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ns
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
LINTFLAGS ?= --lint-only --timescale $(TIMESCALE)
PASS_MSG  ?= RESULT: PASS
RTL_SRCS  ?= verilog/pcie_dbg_pkg.sv verilog/dbg_mem_capture.sv \
             verilog/trace_ring.sv verilog/apb_pcie_regs.sv verilog/pcie_dbg_top.sv

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$($(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -Iverilog --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
